//--- fetch_cfg.svh
// Reset PC, NOP word and memory tag codes for the fetch front end
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

////////////////////////////////////////
// Program counter
////////////////////////////////////////

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// No-operation word delivered on error or flush
`define FETCH_NOP_INSN 32'h1541_0000

////////////////////////////////////////
// Memory response tags
////////////////////////////////////////

`define FETCH_TAG_NONE 4'h0
// Translation miss
`define FETCH_TAG_TE   4'hd
// Protection fault
`define FETCH_TAG_PE   4'hc
// Bus error
`define FETCH_TAG_BE   4'hb

`endif

//--- fetch_pkg.sv
// Address, instruction, memory tag and fetch exception types
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////

	// Word-aligned instruction address
	typedef logic [31:0] addr_t;

	// Raw instruction word
	typedef logic [31:0] insn_t;

	// Tag returned by memory with each word
	typedef logic [3:0] itag_t;

	////////////////////////////////////////
	// Exceptions
	////////////////////////////////////////

	// Exception code carried with a fetched word
	typedef enum logic [1:0] {
		EXC_NONE       = 2'd0,
		EXC_ITLB_MISS  = 2'd1,
		EXC_IMMU_FAULT = 2'd2,
		EXC_IBUS_ERR   = 2'd3
	} fetch_exc_t;

endpackage

`default_nettype wire

//--- fetch_pc_gen.sv
// PC generation stage with advance, hold and flush target load
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc_gen
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_i,
	// Address taken by memory port
	input  logic  pc_take_i,
	// Redirect from decode
	input  logic  flush_i,
	input  addr_t target_i,
	// Next fetch address
	output logic  pc_valid_o,
	output addr_t pc_o
);

	// Next address to fetch
	addr_t pc_q;
	// Low through reset, high once a start address is known
	logic  valid_q;
	// Flush target forced to a word boundary
	addr_t target_aligned;

	assign target_aligned = target_i & ~32'h0000_0003;

	////////////////////////////////////////
	// PC register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q    <= `FETCH_RESET_PC;
			valid_q <= 1'b0;
		end else if (flush_i) begin
			// Redirect wins over a pending take
			pc_q    <= target_aligned;
			valid_q <= 1'b1;
		end else begin
			valid_q <= 1'b1;
			// Sequential advance only when the port took this address
			if (pc_take_i) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

	assign pc_valid_o = valid_q;
	assign pc_o       = pc_q;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Reset value, flush target and increments all keep word alignment
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i)
		pc_valid_o |-> (pc_o[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- fetch_mem_port.sv
// Four-phase req/ack master to instruction memory with tag decode
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_mem_port
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	// From PC stage
	input  logic       pc_valid_i,
	input  addr_t      pc_i,
	output logic       pc_take_o,
	input  logic       flush_i,
	// Instruction memory handshake
	output logic       mem_req_o,
	output addr_t      mem_addr_o,
	input  logic       mem_ack_i,
	input  insn_t      mem_data_i,
	input  itag_t      mem_tag_i,
	// To hold stage
	output logic       rsp_valid_o,
	output addr_t      rsp_pc_o,
	output insn_t      rsp_insn_o,
	output fetch_exc_t rsp_exc_o,
	input  logic       rsp_take_i
);

	// Handshake phases
	typedef enum logic [1:0] {
		S_IDLE     = 2'd0,
		S_REQ      = 2'd1,
		S_REL      = 2'd2,
		S_WAIT_LOW = 2'd3
	} state_t;

	state_t     state_q;
	// Address of the handshake in progress
	addr_t      addr_q;
	// Outstanding handshake belongs to a flushed stream
	logic       stale_q;
	// Captured response and its payload
	logic       rsp_valid_q;
	addr_t      rsp_pc_q;
	insn_t      rsp_insn_q;
	fetch_exc_t rsp_exc_q;
	logic       start;
	logic       capture;

	// Map memory tag to exception, unknown error tags count as bus error
	function automatic fetch_exc_t tag_to_exc(input itag_t tag);
		case (tag)
			`FETCH_TAG_NONE: return EXC_NONE;
			`FETCH_TAG_TE:   return EXC_ITLB_MISS;
			`FETCH_TAG_PE:   return EXC_IMMU_FAULT;
			`FETCH_TAG_BE:   return EXC_IBUS_ERR;
			default:         return EXC_IBUS_ERR;
		endcase
	endfunction

	////////////////////////////////////////
	// Handshake control
	////////////////////////////////////////

	// New request needs a free response slot and no redirect this cycle
	assign start   = (state_q == S_IDLE) && pc_valid_i && !flush_i &&
	                 (!rsp_valid_q || rsp_take_i);
	// Ack seen high while requesting
	assign capture = (state_q == S_REQ) && mem_ack_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: if (start) state_q <= S_REQ;
				S_REQ: if (mem_ack_i) state_q <= S_REL;
				// Request already dropped, ack may still be up
				S_REL: state_q <= mem_ack_i ? S_WAIT_LOW : S_IDLE;
				S_WAIT_LOW: if (!mem_ack_i) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Address latched as the PC stage hands it over
	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= pc_i;
		end
	end

	// Flush during a request lets it finish but marks it for discard
	always_ff @(posedge clk) begin
		if (rst_i) begin
			stale_q <= 1'b0;
		end else if (capture) begin
			stale_q <= 1'b0;
		end else if (flush_i && (state_q == S_REQ)) begin
			stale_q <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Response capture
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			rsp_valid_q <= 1'b0;
		end else if (flush_i) begin
			rsp_valid_q <= 1'b0;
		end else if (capture) begin
			rsp_valid_q <= !stale_q;
		end else if (rsp_take_i) begin
			rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			rsp_pc_q   <= addr_q;
			rsp_insn_q <= mem_data_i;
			rsp_exc_q  <= tag_to_exc(mem_tag_i);
		end
	end

	assign pc_take_o   = start;
	assign mem_req_o   = (state_q == S_REQ);
	assign mem_addr_o  = addr_q;
	assign rsp_valid_o = rsp_valid_q;
	assign rsp_pc_o    = rsp_pc_q;
	assign rsp_insn_o  = rsp_insn_q;
	assign rsp_exc_o   = rsp_exc_q;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Request is held until memory answers, flush or not
	a_req_held: assert property (@(posedge clk) disable iff (rst_i)
		(mem_req_o && !mem_ack_i) |=> mem_req_o);

	// Address does not move under an open request
	a_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
		mem_req_o |=> (!mem_req_o || $stable(mem_addr_o)));

endmodule

`default_nettype wire

//--- fetch_hold.sv
// Fetch output stage that keeps its word under freeze and puts NOP on errors
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_hold
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	// From memory port
	input  logic       rsp_valid_i,
	input  addr_t      rsp_pc_i,
	input  insn_t      rsp_insn_i,
	input  fetch_exc_t rsp_exc_i,
	output logic       rsp_take_o,
	// Decode side
	input  logic       freeze_i,
	input  logic       flush_i,
	output logic       out_valid_o,
	output addr_t      out_pc_o,
	output insn_t      out_insn_o,
	output fetch_exc_t out_exc_o
);

	// Item presented to decode
	logic       valid_q;
	addr_t      pc_q;
	insn_t      insn_q;
	fetch_exc_t exc_q;
	// Decode accepts the current item this cycle
	logic       consume;
	// Word to save, replaced by NOP when fetch failed
	insn_t      insn_next;

	////////////////////////////////////////
	// Accept logic
	////////////////////////////////////////

	assign consume = valid_q && !freeze_i;

	// Room when empty or when the current item leaves now
	// Redirect refuses whatever the port offers this cycle
	assign rsp_take_o = rsp_valid_i && !flush_i && (!valid_q || consume);

	// Faulted fetches never expose the memory data
	assign insn_next = (rsp_exc_i != EXC_NONE) ? `FETCH_NOP_INSN : rsp_insn_i;

	////////////////////////////////////////
	// Saved item
	////////////////////////////////////////

	// Valid flag and exception code are cleared together
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
			exc_q   <= EXC_NONE;
		end else if (flush_i) begin
			// Drop held work on redirect even if frozen
			valid_q <= 1'b0;
			exc_q   <= EXC_NONE;
		end else if (rsp_take_o) begin
			valid_q <= 1'b1;
			exc_q   <= rsp_exc_i;
		end else if (consume) begin
			valid_q <= 1'b0;
			exc_q   <= EXC_NONE;
		end
	end

	// Payload only moves on a take
	always_ff @(posedge clk) begin
		if (rsp_take_o) begin
			pc_q   <= rsp_pc_i;
			insn_q <= insn_next;
		end
	end

	assign out_valid_o = valid_q;
	assign out_pc_o    = pc_q;
	assign out_insn_o  = insn_q;
	assign out_exc_o   = exc_q;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Frozen decode sees the same item next cycle unless redirected
	a_frozen_stable: assert property (@(posedge clk) disable iff (rst_i)
		(out_valid_o && freeze_i && !flush_i) |=>
			(out_valid_o && $stable(out_pc_o) && $stable(out_insn_o) &&
			 $stable(out_exc_o)));

	// No exception reported without an item
	a_exc_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
		!out_valid_o |-> (out_exc_o == EXC_NONE));

	// Tag decode upstream and NOP substitution here stay in step
	a_nop_on_exc: assert property (@(posedge clk) disable iff (rst_i)
		(out_exc_o != EXC_NONE) |-> (out_insn_o == `FETCH_NOP_INSN));

endmodule

`default_nettype wire

//--- fetch_top.sv
// Fetch front end top with PC stage, memory port and hold stage
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	// Instruction memory
	output logic       mem_req_o,
	output addr_t      mem_addr_o,
	input  logic       mem_ack_i,
	input  insn_t      mem_data_i,
	input  itag_t      mem_tag_i,
	// Decode side
	input  logic       freeze_i,
	input  logic       flush_i,
	input  addr_t      target_i,
	output logic       out_valid_o,
	output addr_t      out_pc_o,
	output insn_t      out_insn_o,
	output fetch_exc_t out_exc_o
);

	// PC stage to port
	logic       pc_valid;
	addr_t      pc;
	logic       pc_take;
	// Port to hold stage
	logic       rsp_valid;
	addr_t      rsp_pc;
	insn_t      rsp_insn;
	fetch_exc_t rsp_exc;
	logic       rsp_take;

	fetch_pc_gen fetch_pc_gen_inst (
		.clk        (clk),
		.rst_i      (rst_i),
		.pc_take_i  (pc_take),
		.flush_i    (flush_i),
		.target_i   (target_i),
		.pc_valid_o (pc_valid),
		.pc_o       (pc)
	);

	fetch_mem_port fetch_mem_port_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.pc_valid_i  (pc_valid),
		.pc_i        (pc),
		.pc_take_o   (pc_take),
		.flush_i     (flush_i),
		.mem_req_o   (mem_req_o),
		.mem_addr_o  (mem_addr_o),
		.mem_ack_i   (mem_ack_i),
		.mem_data_i  (mem_data_i),
		.mem_tag_i   (mem_tag_i),
		.rsp_valid_o (rsp_valid),
		.rsp_pc_o    (rsp_pc),
		.rsp_insn_o  (rsp_insn),
		.rsp_exc_o   (rsp_exc),
		.rsp_take_i  (rsp_take)
	);

	fetch_hold fetch_hold_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.rsp_valid_i (rsp_valid),
		.rsp_pc_i    (rsp_pc),
		.rsp_insn_i  (rsp_insn),
		.rsp_exc_i   (rsp_exc),
		.rsp_take_o  (rsp_take),
		.freeze_i    (freeze_i),
		.flush_i     (flush_i),
		.out_valid_o (out_valid_o),
		.out_pc_o    (out_pc_o),
		.out_insn_o  (out_insn_o),
		.out_exc_o   (out_exc_o)
	);

endmodule

`default_nettype wire

//--- tb_imem_model.sv
// Instruction memory model answering the four-phase fetch port, with error regions
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_imem_model
	import fetch_pkg::*;
#(
	parameter int seed_init = 16
) (
	input  logic  clk,
	input  logic  rst_i,
	input  logic  mem_req_i,
	input  addr_t mem_addr_i,
	output logic  mem_ack_o,
	output insn_t mem_data_o,
	output itag_t mem_tag_o
);

	// Delay draws
	integer     seed;
	int         rnd;
	// Request seen, ack not yet raised
	logic       pending;
	// Extra cycles before ack, 0 to 3
	logic [1:0] wait_cnt;

	// Fault regions of four words each
	function automatic itag_t tag_for(input addr_t addr);
		if (addr >= 32'h0000_0100 && addr < 32'h0000_0110) begin
			return `FETCH_TAG_TE;
		end else if (addr >= 32'h0000_0200 && addr < 32'h0000_0210) begin
			return `FETCH_TAG_PE;
		end else if (addr >= 32'h0000_0300 && addr < 32'h0000_0310) begin
			return `FETCH_TAG_BE;
		end
		return `FETCH_TAG_NONE;
	endfunction

	////////////////////////////////////////
	// Responder, all outputs move on the falling edge
	////////////////////////////////////////

	initial begin
		seed       = seed_init;
		mem_ack_o  = 1'b0;
		mem_data_o = '0;
		mem_tag_o  = `FETCH_TAG_NONE;
		pending    = 1'b0;
		wait_cnt   = 2'd0;
		forever begin
			@(negedge clk);
			if (rst_i) begin
				mem_ack_o = 1'b0;
				pending   = 1'b0;
			end else if (mem_ack_o) begin
				// Return to zero once the master lets go
				if (!mem_req_i) begin
					mem_ack_o = 1'b0;
				end
			end else if (pending) begin
				if (wait_cnt == 2'd0) begin
					mem_data_o = mem_addr_i ^ 32'h5A5A_0000;
					mem_tag_o  = tag_for(mem_addr_i);
					mem_ack_o  = 1'b1;
					pending    = 1'b0;
				end else begin
					wait_cnt = wait_cnt - 2'd1;
				end
			end else if (mem_req_i) begin
				// New request, pick its latency
				rnd      = $random(seed);
				wait_cnt = rnd[1:0];
				pending  = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_fetch.sv
// Testbench for the fetch front end with reference model, checker and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch
	import fetch_pkg::*;
();

	// Items consumed in each test and the basis of the watchdog budget
	localparam int seq_items     = 24;
	localparam int rand_items    = 40;
	localparam int region_items  = 8;
	localparam int flush_items   = 10;
	localparam int restart_items = 6;
	localparam int total_items   = seq_items + rand_items + 3 * region_items +
	                               2 * flush_items + 3 * restart_items;

	logic       clk;
	logic       rst;
	logic       mem_req;
	addr_t      mem_addr;
	logic       mem_ack;
	insn_t      mem_data;
	itag_t      mem_tag;
	logic       freeze;
	logic       flush;
	addr_t      target;
	logic       out_valid;
	addr_t      out_pc;
	insn_t      out_insn;
	fetch_exc_t out_exc;

	integer     seed;
	int         errors;
	int         test_errors;
	int         tests;
	int         consumed;
	int         test_items;
	string      test_name;
	// Next pc decode should see
	addr_t      exp_pc;
	// Item seen frozen last cycle
	logic       held_valid;
	addr_t      held_pc;
	insn_t      held_insn;
	fetch_exc_t held_exc;

	fetch_top fetch_top_inst (
		.clk         (clk),
		.rst_i       (rst),
		.mem_req_o   (mem_req),
		.mem_addr_o  (mem_addr),
		.mem_ack_i   (mem_ack),
		.mem_data_i  (mem_data),
		.mem_tag_i   (mem_tag),
		.freeze_i    (freeze),
		.flush_i     (flush),
		.target_i    (target),
		.out_valid_o (out_valid),
		.out_pc_o    (out_pc),
		.out_insn_o  (out_insn),
		.out_exc_o   (out_exc)
	);

	tb_imem_model imem_inst (
		.clk        (clk),
		.rst_i      (rst),
		.mem_req_i  (mem_req),
		.mem_addr_i (mem_addr),
		.mem_ack_o  (mem_ack),
		.mem_data_o (mem_data),
		.mem_tag_o  (mem_tag)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Reference and compare
	////////////////////////////////////////

	// Expected word and exception for a pc with NOP on any fault
	function automatic void ref_fetch(input addr_t pc, output insn_t insn,
	                                  output fetch_exc_t exc);
		if (pc >= 32'h0000_0100 && pc < 32'h0000_0110) begin
			exc = EXC_ITLB_MISS;
		end else if (pc >= 32'h0000_0200 && pc < 32'h0000_0210) begin
			exc = EXC_IMMU_FAULT;
		end else if (pc >= 32'h0000_0300 && pc < 32'h0000_0310) begin
			exc = EXC_IBUS_ERR;
		end else begin
			exc = EXC_NONE;
		end
		insn = (exc == EXC_NONE) ? (pc ^ 32'h5A5A_0000) : `FETCH_NOP_INSN;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	// Outputs sampled on the rising edge before the DUT updates
	always @(posedge clk) begin
		insn_t      exp_insn;
		fetch_exc_t exp_exc;
		if (rst) begin
			exp_pc     = `FETCH_RESET_PC;
			held_valid = 1'b0;
		end else begin
			// Frozen item unchanged one cycle later
			if (held_valid) begin
				check_value("held valid", 32'd1, {31'd0, out_valid});
				check_value("held pc", held_pc, out_pc);
				check_value("held insn", held_insn, out_insn);
				check_value("held exc", {30'd0, held_exc}, {30'd0, out_exc});
			end
			if (out_valid && !freeze && !flush) begin
				ref_fetch(exp_pc, exp_insn, exp_exc);
				check_value("pc", exp_pc, out_pc);
				check_value("insn", exp_insn, out_insn);
				check_value("exc", {30'd0, exp_exc}, {30'd0, out_exc});
				exp_pc = exp_pc + 32'd4;
				consumed++;
				test_items++;
			end
			// Restart at the word holding the target
			if (flush) begin
				exp_pc = {target[31:2], 2'b00};
			end
			held_valid = out_valid && freeze && !flush;
			held_pc    = out_pc;
			held_insn  = out_insn;
			held_exc   = out_exc;
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		test_items  = 0;
		tests++;
	endtask

	task automatic end_test();
		$display("Test %s finished: %0d items, %0d mismatches", test_name, test_items,
		         test_errors);
	endtask

	// Decode takes n items with optional random stalls and stays frozen on exit
	task automatic consume_items(input int n, input logic random_stall);
		int   goal;
		int   rnd;
		logic done;
		goal = consumed + n;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (consumed >= goal) begin
				freeze = 1'b1;
				done   = 1'b1;
			end else begin
				rnd    = $random(seed);
				freeze = random_stall ? rnd[0] : 1'b0;
			end
		end
	endtask

	// Single redirect cycle with decode frozen
	task automatic flush_to(input addr_t addr);
		@(negedge clk);
		freeze = 1'b1;
		flush  = 1'b1;
		target = addr;
		@(negedge clk);
		flush = 1'b0;
	endtask

	// Redirect while a request is open behind a held item
	task automatic flush_in_flight(input addr_t addr);
		int   rnd;
		logic found;
		found = 1'b0;
		while (!found) begin
			@(negedge clk);
			if (mem_req && out_valid) begin
				found = 1'b1;
			end else begin
				rnd    = $random(seed);
				freeze = rnd[0];
			end
		end
		freeze = 1'b1;
		flush  = 1'b1;
		target = addr;
		@(negedge clk);
		flush = 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		seed        = 16;
		rst         = 1'b1;
		freeze      = 1'b0;
		flush       = 1'b0;
		target      = '0;
		errors      = 0;
		test_errors = 0;
		tests       = 0;
		consumed    = 0;
		test_items  = 0;
		held_valid  = 1'b0;
		test_name   = "reset";
		repeat (16) @(negedge clk);

		start_test("reset");
		check_value("mem_req", 32'd0, {31'd0, mem_req});
		check_value("out_valid", 32'd0, {31'd0, out_valid});
		check_value("out_exc", {30'd0, EXC_NONE}, {30'd0, out_exc});
		rst = 1'b0;
		end_test();

		start_test("sequential");
		consume_items(seq_items, 1'b0);
		end_test();

		start_test("random_freeze");
		consume_items(rand_items, 1'b1);
		end_test();

		// Each window starts two words before a fault region
		start_test("error_regions");
		flush_to(32'h0000_00F8);
		consume_items(region_items, 1'b1);
		flush_to(32'h0000_01F8);
		consume_items(region_items, 1'b1);
		flush_to(32'h0000_02F8);
		consume_items(region_items, 1'b1);
		end_test();

		start_test("flush_outstanding");
		flush_in_flight(32'h0000_0400);
		consume_items(flush_items, 1'b1);
		flush_in_flight(32'h0000_00FC);
		consume_items(flush_items, 1'b1);
		end_test();

		// Two redirects in consecutive cycles where the last one wins
		start_test("flush_restart");
		@(negedge clk);
		freeze = 1'b1;
		flush  = 1'b1;
		target = 32'h0000_0500;
		@(negedge clk);
		target = 32'h0000_0600;
		@(negedge clk);
		flush = 1'b0;
		consume_items(restart_items, 1'b1);
		flush_to(32'h0000_0208);
		consume_items(restart_items, 1'b1);
		// Unaligned target lands on 0x30C
		flush_to(32'h0000_030E);
		consume_items(restart_items, 1'b1);
		end_test();

		$display("Tests: %0d, items checked: %0d, mismatches: %0d", tests, consumed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Budget of 16 cycles per item
	initial begin
		#(total_items * 16 * 8);
		$display("Timeout: fetch stopped delivering items during test %s", test_name);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
fetch_mem_port.sv
fetch_hold.sv
fetch_top.sv
tb_imem_model.sv
tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

SOURCES := fetch_cfg.svh fetch_pkg.sv fetch_pc_gen.sv fetch_mem_port.sv fetch_hold.sv \
	fetch_top.sv tb_imem_model.sv tb_fetch.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_fetch: project.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_fetch -f project.f -o Vtb_fetch

run: obj_dir/Vtb_fetch
	./obj_dir/Vtb_fetch > sim.log 2>&1; cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
